// ==== src/motorPwm_config.svh ====
`ifndef MOTOR_PWM_CONFIG_SVH
`define MOTOR_PWM_CONFIG_SVH

// width of the PWM period length and of the period down-counter
`define PWM_LEN_W 12

// width of the position accumulators, the pulse counter and lostPos
`define POS_W 16

// width of the step window length and of the window cycle counter
`define STEP_CNT_W 25

// number of commutation step indices walked by the sequencer
`define STEP_COUNT 12

// width of the step index, wide enough to hold STEP_COUNT - 1
`define STEP_W 4

// shortest pulse the MOSFET drivers can follow, in clock cycles
// requests below this are merged into a later period
`define PWM_MIN_PULSE 256

`endif

// ==== src/motorPwmPkg.sv ====
package motorPwmPkg;

    // decision taken at the last cycle of each PWM period
    //   loadNow  : the pending high time is long enough and is emitted as a pulse
    //   minLimit : the pending high time is still too short and is carried on
    //   noActive : the sequencer is stopped and nothing is emitted
    typedef enum logic [1:0] {
        loadNow  = 2'd0,
        minLimit = 2'd1,
        noActive = 2'd2
    } skipReason_t;

    // the step sequencer either waits for enable or walks the step windows
    typedef enum logic {
        seqIdle = 1'b0,
        seqRun  = 1'b1
    } seqState_t;

endpackage

// ==== src/stepBusIf.sv ====
`timescale 1ns/1ps

`include "motorPwm_config.svh"

// step timing shared between the sequencer and the phase generator
interface stepBusIf;

    // current commutation step index
    logic [`STEP_W-1:0] step;

    // one-cycle strobes at the first and the last cycle of a step window
    logic               winFirst;
    logic               winLast;

    // high while the sequencer is running
    logic               active;

    modport source (
        output step,
        output winFirst,
        output winLast,
        output active
    );

    modport sink (
        input  step,
        input  winFirst,
        input  winLast,
        input  active
    );

endinterface

// ==== src/stepSequencer.sv ====
`timescale 1ns/1ps

`include "motorPwm_config.svh"

module stepSequencer
    import motorPwmPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  logic [`STEP_CNT_W-1:0] stepCycles,
    stepBusIf.source               bus
);

    seqState_t              state;
    logic [`STEP_CNT_W-1:0] winCnt;
    logic [`STEP_W-1:0]     stepIdx;
    logic                   running;
    logic                   cntLast;
    logic                   stepWrap;

    assign running = (state == seqRun);

    // the window counter runs from 0 up to stepCycles - 1
    assign cntLast = (winCnt == stepCycles - 1'b1);

    assign stepWrap = (stepIdx == `STEP_W'(`STEP_COUNT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= seqIdle;
        end else begin
            case (state)
                seqIdle: begin
                    if (enable) begin
                        state <= seqRun;
                    end
                end
                seqRun: begin
                    if (!enable) begin
                        state <= seqIdle;
                    end
                end
                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

    // held at zero while idle so the first running cycle is a window start
    always_ff @(posedge clk) begin
        if (reset || !running) begin
            winCnt <= '0;
        end else if (cntLast) begin
            winCnt <= '0;
        end else begin
            winCnt <= winCnt + 1'b1;
        end
    end

    // every start from idle begins at step 0; the index keeps its value while stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            stepIdx <= '0;
        end else if (!running) begin
            if (enable) begin
                stepIdx <= '0;
            end
        end else if (cntLast) begin
            if (stepWrap) begin
                stepIdx <= '0;
            end else begin
                stepIdx <= stepIdx + 1'b1;
            end
        end
    end

    assign bus.active   = running;
    assign bus.step     = stepIdx;
    assign bus.winFirst = running && (winCnt == '0);
    assign bus.winLast  = running && cntLast;

endmodule

// ==== src/pwmPhaseGenerator.sv ====
`timescale 1ns/1ps

`include "motorPwm_config.svh"

module pwmPhaseGenerator
    import motorPwmPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    stepBusIf.sink                bus,
    input  logic [`PWM_LEN_W-1:0] pwmLenWant,
    input  logic [`POS_W-1:0]     pwmLenPos,
    output logic                  pwm,
    output logic                  highSide,
    output logic [`POS_W-1:0]     lostPos
);

    logic [`PWM_LEN_W-1:0] pwmCnt;
    logic                  periodEnd;

    logic [`POS_W-1:0]     posRemain;
    logic [`POS_W-1:0]     posSum;
    skipReason_t           skip;

    logic [`POS_W-1:0]     pulseCnt;

    logic [`POS_W-1:0]     posWant;
    logic [`POS_W-1:0]     posReal;
    logic [`POS_W-1:0]     posDiff;

    // the window start is itself a period boundary, so only later counter
    // expiries inside the window count as period ends
    assign periodEnd = bus.active && !bus.winFirst && (pwmCnt == `PWM_LEN_W'(1));

    always_ff @(posedge clk) begin
        if (reset || !bus.active || bus.winFirst) begin
            pwmCnt <= pwmLenWant;
        end else if (pwmCnt == `PWM_LEN_W'(1)) begin
            pwmCnt <= pwmLenWant;
        end else begin
            pwmCnt <= pwmCnt - 1'b1;
        end
    end

    // posRemain holds the high time requested but not yet emitted,
    // including the request of the period now running
    assign posSum = posRemain + pwmLenPos;

    always_comb begin
        if (!bus.active) begin
            skip = noActive;
        end else if (posRemain < `POS_W'(`PWM_MIN_PULSE)) begin
            skip = minLimit;
        end else begin
            skip = loadNow;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !bus.active) begin
            posRemain <= '0;
        end else if (bus.winFirst) begin
            posRemain <= pwmLenPos;
        end else if (periodEnd) begin
            if (skip == loadNow) begin
                posRemain <= pwmLenPos;
            end else begin
                posRemain <= posSum;
            end
        end
    end

    // a pulse never crosses into the next window
    always_ff @(posedge clk) begin
        if (reset || !bus.active || bus.winLast) begin
            pulseCnt <= '0;
        end else if (periodEnd && (skip == loadNow)) begin
            pulseCnt <= posRemain;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    assign pwm = (pulseCnt != '0);

    // wanted high cycles of the current window, one request per period
    always_ff @(posedge clk) begin
        if (reset || !bus.active) begin
            posWant <= '0;
        end else if (bus.winFirst) begin
            posWant <= pwmLenPos;
        end else if (periodEnd) begin
            posWant <= posWant + pwmLenPos;
        end
    end

    // delivered high cycles of the current window
    // pwm is always low at winFirst because winLast cleared the pulse
    always_ff @(posedge clk) begin
        if (reset || !bus.active || bus.winFirst) begin
            posReal <= '0;
        end else if (pwm) begin
            posReal <= posReal + 1'b1;
        end
    end

    // in the winFirst cycle both accumulators still hold the previous window
    assign posDiff = posWant - posReal;

    always_ff @(posedge clk) begin
        if (reset) begin
            lostPos <= '0;
        end else if (bus.winFirst) begin
            if (posDiff[`POS_W-1]) begin
                lostPos <= -posDiff;
            end else begin
                lostPos <= posDiff;
            end
        end
    end

    // steps in the first half of the sequence drive the high side
    assign highSide = (bus.step < `STEP_W'(`STEP_COUNT / 2));

endmodule

// ==== src/motorPwmTop.sv ====
`timescale 1ns/1ps

`include "motorPwm_config.svh"

module motorPwmTop (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  logic [`STEP_CNT_W-1:0] stepCycles,
    input  logic [`PWM_LEN_W-1:0]  pwmLenWant,
    input  logic [`POS_W-1:0]      pwmLenPos,
    output logic                   pwm,
    output logic                   highSide,
    output logic [`POS_W-1:0]      lostPos,
    output logic [`STEP_W-1:0]     step
);

    // step strobes from the sequencer to the phase generator
    stepBusIf stepBus ();

    stepSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .stepCycles (stepCycles),
        .bus        (stepBus.source)
    );

    pwmPhaseGenerator phaseGen (
        .clk        (clk),
        .reset      (reset),
        .bus        (stepBus.sink),
        .pwmLenWant (pwmLenWant),
        .pwmLenPos  (pwmLenPos),
        .pwm        (pwm),
        .highSide   (highSide),
        .lostPos    (lostPos)
    );

    // the current step index is also made visible at the pins
    assign step = stepBus.step;

endmodule

// ==== testbench/motorPwm_checker.sv ====
`timescale 1ns/1ps

`include "motorPwm_config.svh"

module motorPwm_checker (
    input logic              clk,
    input logic              reset,
    input logic              active,
    input logic              winFirst,
    input logic              winLast,
    input logic              pwm,
    input logic [`POS_W-1:0] lostPos
);

    // goes high one cycle after the first window start that follows reset
    logic firstSeen;

    always_ff @(posedge clk) begin
        if (reset) begin
            firstSeen <= 1'b0;
        end else if (active && winFirst) begin
            firstSeen <= 1'b1;
        end
    end

    // a running pulse is cleared one cycle after the sequencer stops
    pwmIdle: assert property (@(posedge clk) disable iff (reset) !active |=> !pwm)
        else $error("pwm still high one cycle after the sequencer stopped");

    // a window end is followed by the next window start unless the run stops
    winChain: assert property (@(posedge clk) disable iff (reset)
        winLast |=> (!active || winFirst))
        else $error("window end not followed by a window start");

    lostHold: assert property (@(posedge clk) disable iff (reset)
        !firstSeen |-> (lostPos == '0))
        else $error("lostPos changed before the first window start");

endmodule

bind pwmPhaseGenerator motorPwm_checker phaseCheck (
    .clk      (clk),
    .reset    (reset),
    .active   (bus.active),
    .winFirst (bus.winFirst),
    .winLast  (bus.winLast),
    .pwm      (pwm),
    .lostPos  (lostPos)
);

// ==== testbench/motorPwmTb.sv ====
`timescale 1ns/1ps

`include "motorPwm_config.svh"

module motorPwmTb;

    logic                   clk;
    logic                   reset;
    logic                   enable;
    logic [`STEP_CNT_W-1:0] stepCycles;
    logic [`PWM_LEN_W-1:0]  pwmLenWant;
    logic [`POS_W-1:0]      pwmLenPos;
    logic                   pwm;
    logic                   highSide;
    logic [`POS_W-1:0]      lostPos;
    logic [`STEP_W-1:0]     step;

    int errorCount;
    int testCount;
    int failedCount;

    motorPwmTop uut (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .stepCycles (stepCycles),
        .pwmLenWant (pwmLenWant),
        .pwmLenPos  (pwmLenPos),
        .pwm        (pwm),
        .highSide   (highSide),
        .lostPos    (lostPos),
        .step       (step)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic reportMismatch(input string testName, input string what,
                                  input int expected, input int actual);
        $display("error %s: %s expected %0d actual %0d", testName, what, expected, actual);
        errorCount++;
    endtask

    task automatic reportProblem(input string testName, input string text);
        $display("error %s: %s", testName, text);
        errorCount++;
    endtask

    task automatic finishTest(input string testName, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %s done with no errors", testName);
        end else begin
            failedCount++;
            $display("test %s done with %0d errors", testName, errorCount - errorsBefore);
        end
    endtask

    // returns at the sampling point of the first cycle of window 0
    task automatic startRun(input int cycles, input int lenWant, input int lenPos);
        @(posedge clk);
        stepCycles <= `STEP_CNT_W'(cycles);
        pwmLenWant <= `PWM_LEN_W'(lenWant);
        pwmLenPos  <= `POS_W'(lenPos);
        enable     <= 1'b1;
        @(posedge clk);
        @(negedge clk);
    endtask

    // one edge stops the sequencer and one more lets the generator clear its pulse
    task automatic stopRun();
        @(posedge clk);
        enable <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    // counts one window from its first cycle up to the next step change
    task automatic measureWindow(input int limit, output int cycles, output int highCycles,
                                 output int pulses, output bit timedOut);
        logic [`STEP_W-1:0] startStep;
        logic               prevPwm;
        startStep = step;
        prevPwm = 1'b0;
        cycles = 0;
        highCycles = 0;
        pulses = 0;
        timedOut = 1'b0;
        while (!timedOut && step == startStep) begin
            if (pwm) highCycles++;
            if (pwm && !prevPwm) pulses++;
            prevPwm = pwm;
            cycles++;
            @(negedge clk);
            if (cycles > limit) timedOut = 1'b1;
        end
    endtask

    task automatic checkIdleOutputs(input string testName);
        if (pwm != 1'b0) reportMismatch(testName, "pwm", 0, int'(pwm));
        if (lostPos != '0) reportMismatch(testName, "lostPos", 0, int'(lostPos));
        if (step != '0) reportMismatch(testName, "step", 0, int'(step));
        if (highSide != 1'b1) reportMismatch(testName, "highSide", 1, int'(highSide));
    endtask

    task automatic runGoldenTest(input string name, input int cycles, input int lenWant,
                                 input int lenPos, input int expHigh, input int expPulses,
                                 input int expLost);
        int errorsBefore;
        int winCycles;
        int highCycles;
        int pulses;
        bit timedOut;
        errorsBefore = errorCount;
        startRun(cycles, lenWant, lenPos);
        // window 0 settles the generator and window 1 is the one compared
        measureWindow(cycles + 8, winCycles, highCycles, pulses, timedOut);
        if (!timedOut) measureWindow(cycles + 8, winCycles, highCycles, pulses, timedOut);
        if (timedOut) begin
            reportProblem(name, "step window did not end in time");
        end else begin
            if (winCycles != cycles) reportMismatch(name, "window cycles", cycles, winCycles);
            if (highCycles != expHigh) reportMismatch(name, "high cycles", expHigh, highCycles);
            if (pulses != expPulses) reportMismatch(name, "pulse count", expPulses, pulses);
            // lostPos of window 1 is registered in the first cycle of window 2
            @(negedge clk);
            if (lostPos != `POS_W'(expLost)) begin
                reportMismatch(name, "lostPos", expLost, int'(lostPos));
            end
        end
        stopRun();
        finishTest(name, errorsBefore);
    endtask

    task automatic runStepWalk();
        int  errorsBefore;
        int  expStep;
        int  winCycles;
        int  highCycles;
        int  pulses;
        bit  timedOut;
        errorsBefore = errorCount;
        timedOut = 1'b0;
        expStep = 0;
        startRun(60, 20, 0);
        if (step != '0) reportMismatch("stepWalk", "first step", 0, int'(step));
        for (int i = 0; i < 13 && !timedOut; i++) begin
            measureWindow(68, winCycles, highCycles, pulses, timedOut);
            if (timedOut) begin
                reportProblem("stepWalk", "step did not advance in time");
            end else begin
                expStep = (expStep + 1) % `STEP_COUNT;
                if (winCycles != 60) reportMismatch("stepWalk", "window cycles", 60, winCycles);
                if (int'(step) != expStep) reportMismatch("stepWalk", "step", expStep, int'(step));
                if (int'(highSide) != ((expStep < `STEP_COUNT / 2) ? 1 : 0)) begin
                    reportMismatch("stepWalk", "highSide", (expStep < `STEP_COUNT / 2) ? 1 : 0,
                                   int'(highSide));
                end
            end
        end
        stopRun();
        finishTest("stepWalk", errorsBefore);
    endtask

    task automatic runDisable();
        int                 errorsBefore;
        int                 waitCycles;
        logic [`STEP_W-1:0] heldStep;
        errorsBefore = errorCount;
        waitCycles = 0;
        startRun(200, 100, 300);
        // stop inside window 1 so that the restart has to bring the step back to 0
        while (step == '0 && waitCycles < 400) begin
            @(negedge clk);
            waitCycles++;
        end
        if (step == '0) reportProblem("disable", "step never left 0 before the disable");
        waitCycles = 0;
        while (!pwm && waitCycles < 400) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!pwm) reportProblem("disable", "pwm never went high before the disable");
        stopRun();
        heldStep = step;
        for (int i = 0; i < 1000; i++) begin
            if (pwm) begin
                reportMismatch("disable", "pwm while stopped", 0, 1);
                break;
            end
            if (step != heldStep) begin
                reportMismatch("disable", "step while stopped", int'(heldStep), int'(step));
                break;
            end
            @(negedge clk);
        end
        startRun(200, 100, 300);
        if (step != '0) reportMismatch("disable", "step after restart", 0, int'(step));
        stopRun();
        finishTest("disable", errorsBefore);
    endtask

    function automatic string nameFromBits(input logic [8*24-1:0] bits);
        string text;
        text = "";
        for (int i = 23; i >= 0; i--) begin
            if (bits[8*i +: 8] != 8'd0) text = $sformatf("%s%c", text, bits[8*i +: 8]);
        end
        return text;
    endfunction

    initial begin
        string           line;
        logic [8*24-1:0] nameBits;
        int              fd;
        int              fields;
        int              vectors;
        int              cycles;
        int              lenWant;
        int              lenPos;
        int              expHigh;
        int              expPulses;
        int              expLost;
        int              errorsBefore;
        errorCount = 0;
        testCount = 0;
        failedCount = 0;
        vectors = 0;
        reset      <= 1'b1;
        enable     <= 1'b0;
        stepCycles <= `STEP_CNT_W'(100);
        pwmLenWant <= `PWM_LEN_W'(50);
        pwmLenPos  <= '0;

        // outputs are checked inside the reset interval and just after it
        errorsBefore = errorCount;
        repeat (2) @(posedge clk);
        repeat (6) begin
            @(negedge clk);
            checkIdleOutputs("reset");
            @(posedge clk);
        end
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            checkIdleOutputs("reset");
        end
        finishTest("reset", errorsBefore);

        fd = $fopen("testbench/motorPwm_golden.txt", "r");
        if (fd == 0) begin
            reportProblem("golden", "the golden file could not be opened");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    fields = $sscanf(line, "%s %d %d %d %d %d %d", nameBits, cycles, lenWant,
                                     lenPos, expHigh, expPulses, expLost);
                    if (fields == 7) begin
                        vectors++;
                        runGoldenTest(nameFromBits(nameBits), cycles, lenWant, lenPos,
                                      expHigh, expPulses, expLost);
                    end
                end
            end
            $fclose(fd);
            if (vectors == 0) reportProblem("golden", "no test vectors found in the golden file");
        end

        runStepWalk();
        runDisable();

        $display("%0d tests run, %0d failed, %0d errors", testCount, failedCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/motorPwm_golden.txt ====
# name stepCycles pwmLenWant pwmLenPos highCyclesPerWindow pulsesPerWindow lostPos
# one test per line, the counts are for one whole step window
fullPulse   1600 400 300 900  3 300
fullWide    3000 500 450 2250 5 450
exactMin    1200 300 256 768  3 256
pulseFill   1600 400 400 1199 1 401
minMerge    2200 200 100 900  3 200
minTruncate 2000 200 100 799  3 201
minSlow     1500 100 60  600  2 300
zeroPos     1000 250 0   0    0 0

// ==== compile.f ====
+incdir+src
src/motorPwmPkg.sv
src/stepBusIf.sv
src/stepSequencer.sv
src/pwmPhaseGenerator.sv
src/motorPwmTop.sv
testbench/motorPwm_checker.sv
testbench/motorPwmTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the motor PWM testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/VmotorPwmTb

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module motorPwmTb -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -qF "*** TEST FAILED ***" "$LOG"
found=$?
if [ $found -eq 0 ]; then
    echo "simulation reported a failure"
    exit 1
elif [ $found -ne 1 ]; then
    echo "could not search $LOG"
    exit 1
fi

exit 0
